// File: verilog/qu_common_pkg.sv
// Common widths and types
package qu_common_pkg;

    // Register file geometry
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    // Operand and result width
    localparam int DATA_W = 32;

    // Reservation station geometry, the entry index is the producer tag
    localparam int RS_TAG_W = 3;
    localparam int RS_DEPTH = 8;

    // Physical register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Operand and result value
    typedef logic [DATA_W-1:0] data_t;

    // Station index used as producer tag
    typedef logic [RS_TAG_W-1:0] rs_tag_t;

endpackage

// File: verilog/qu_uop_pkg.sv
// Micro-op and bus formats
package qu_uop_pkg;

    // Operations handled by the execution unit
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } op_e;

    // Incoming micro-op
    typedef struct packed {
        logic                      valid;
        op_e                       op;
        qu_common_pkg::reg_addr_t  rs1;
        qu_common_pkg::reg_addr_t  rs2;
        qu_common_pkg::reg_addr_t  rd;
    } uop_t;

    // Reservation station entry, each operand is a value or a pending tag
    typedef struct packed {
        logic                      busy;
        op_e                       op;
        logic                      qj_pend;
        qu_common_pkg::rs_tag_t    qj;
        qu_common_pkg::data_t      vj;
        logic                      qk_pend;
        qu_common_pkg::rs_tag_t    qk;
        qu_common_pkg::data_t      vk;
        qu_common_pkg::reg_addr_t  rd;
    } res_st_cell_t;

    // Common data bus broadcast
    typedef struct packed {
        logic                      valid;
        qu_common_pkg::rs_tag_t    tag;
        qu_common_pkg::reg_addr_t  rd;
        qu_common_pkg::data_t      value;
    } cdb_t;

endpackage

// File: verilog/busy_table.sv
// Register busy table
`timescale 1ns/1ps

module busy_table
#(
    parameter int REG_COUNT = qu_common_pkg::REG_COUNT
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      busy_set,
    input  qu_common_pkg::reg_addr_t  busy_set_addr,
    input  logic                      busy_clr,
    input  qu_common_pkg::reg_addr_t  busy_clr_addr,
    input  qu_common_pkg::reg_addr_t  rd1_addr,
    input  qu_common_pkg::reg_addr_t  rd2_addr,
    output logic                      rd1_busy,
    output logic                      rd2_busy
);

    // One pending write bit per register
    logic [REG_COUNT-1:0] busy;

    assign rd1_busy = busy[rd1_addr];
    assign rd2_busy = busy[rd2_addr];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= '0;
        end
        else
        begin
            if (busy_clr)
                busy[busy_clr_addr] <= 1'b0;
            // Set comes last so a new producer wins
            if (busy_set)
                busy[busy_set_addr] <= 1'b1;
        end
    end

endmodule

// File: verilog/phy_reg_file.sv
// Physical register file
`timescale 1ns/1ps

module phy_reg_file
#(
    parameter int REG_COUNT = qu_common_pkg::REG_COUNT
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  qu_common_pkg::reg_addr_t  rd1_addr,
    input  qu_common_pkg::reg_addr_t  rd2_addr,
    output qu_common_pkg::data_t      rd1_data,
    output qu_common_pkg::data_t      rd2_data,
    input  qu_uop_pkg::cdb_t          cdb_in
);

    qu_common_pkg::data_t regs [REG_COUNT];

    // Combinational read ports
    assign rd1_data = regs[rd1_addr];
    assign rd2_data = regs[rd2_addr];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // Each register starts out holding its own index
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= qu_common_pkg::data_t'(i);
            end
        end
        else if (cdb_in.valid)
        begin
            regs[cdb_in.rd] <= cdb_in.value;
        end
    end

endmodule

// File: verilog/rename.sv
// Rename and dispatch stage
`timescale 1ns/1ps

module rename
#(
    parameter int REG_COUNT = qu_common_pkg::REG_COUNT,
    parameter int RS_DEPTH  = qu_common_pkg::RS_DEPTH
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  qu_uop_pkg::uop_t           uop_in,
    output qu_common_pkg::reg_addr_t   bt_rd1_addr,
    output qu_common_pkg::reg_addr_t   bt_rd2_addr,
    input  logic                       bt_rd1_busy,
    input  logic                       bt_rd2_busy,
    output qu_common_pkg::reg_addr_t   rf_rd1_addr,
    output qu_common_pkg::reg_addr_t   rf_rd2_addr,
    input  qu_common_pkg::data_t       rf_rd1_data,
    input  qu_common_pkg::data_t       rf_rd2_data,
    input  qu_uop_pkg::cdb_t           cdb_in,
    output logic                       busy_set,
    output logic                       busy_clr,
    output qu_common_pkg::reg_addr_t   busy_set_addr,
    output qu_common_pkg::reg_addr_t   busy_clr_addr,
    output logic                       rs_wr_en,
    output qu_common_pkg::rs_tag_t     rs_wr_addr,
    output qu_uop_pkg::res_st_cell_t   rs_wr_cell
);

    // Latest producer of every register
    qu_common_pkg::rs_tag_t prod_tag [REG_COUNT];
    qu_common_pkg::rs_tag_t wr_ptr;
    qu_common_pkg::rs_tag_t src1_tag;
    qu_common_pkg::rs_tag_t src2_tag;

    assign bt_rd1_addr = uop_in.rs1;
    assign bt_rd2_addr = uop_in.rs2;
    assign rf_rd1_addr = uop_in.rs1;
    assign rf_rd2_addr = uop_in.rs2;

    assign src1_tag = prod_tag[uop_in.rs1];
    assign src2_tag = prod_tag[uop_in.rs2];

    assign rs_wr_en      = uop_in.valid;
    assign rs_wr_addr    = wr_ptr;
    assign busy_set      = uop_in.valid;
    assign busy_set_addr = uop_in.rd;

    // Only the current producer of rd may release it
    assign busy_clr      = cdb_in.valid && (prod_tag[cdb_in.rd] == cdb_in.tag);
    assign busy_clr_addr = cdb_in.rd;

    always_comb
    begin
        rs_wr_cell.busy    = 1'b1;
        rs_wr_cell.op      = uop_in.op;
        rs_wr_cell.rd      = uop_in.rd;
        rs_wr_cell.qj      = src1_tag;
        rs_wr_cell.qk      = src2_tag;
        rs_wr_cell.qj_pend = 1'b0;
        rs_wr_cell.qk_pend = 1'b0;
        rs_wr_cell.vj      = rf_rd1_data;
        rs_wr_cell.vk      = rf_rd2_data;

        // Producer broadcasting right now is forwarded from the bus
        if (bt_rd1_busy)
        begin
            if (cdb_in.valid && cdb_in.tag == src1_tag)
                rs_wr_cell.vj = cdb_in.value;
            else
                rs_wr_cell.qj_pend = 1'b1;
        end

        if (bt_rd2_busy)
        begin
            if (cdb_in.valid && cdb_in.tag == src2_tag)
                rs_wr_cell.vk = cdb_in.value;
            else
                rs_wr_cell.qk_pend = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            prod_tag <= '{default: '0};
        end
        else if (uop_in.valid)
        begin
            prod_tag[uop_in.rd] <= wr_ptr;
            if (wr_ptr == qu_common_pkg::rs_tag_t'(RS_DEPTH - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // A colliding clear must come from an older producer, so the new set wins
    assert property (@(posedge clk) disable iff (rst)
        (busy_set && busy_clr && busy_set_addr == busy_clr_addr)
            |-> cdb_in.tag != rs_wr_addr)
        else $error("busy clear from the tag being reassigned to r%0d", busy_set_addr);

endmodule

// File: verilog/res_station.sv
// Reservation station
`timescale 1ns/1ps

module res_station
#(
    parameter int RS_DEPTH = qu_common_pkg::RS_DEPTH
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  qu_common_pkg::rs_tag_t    wr_addr,
    input  qu_uop_pkg::res_st_cell_t  wr_cell,
    input  qu_uop_pkg::cdb_t          cdb_in,
    output logic [RS_DEPTH-1:0]       ready,
    input  logic                      issue_en,
    input  qu_common_pkg::rs_tag_t    issue_tag,
    output qu_uop_pkg::res_st_cell_t  issue_cell
);

    qu_uop_pkg::res_st_cell_t cells [RS_DEPTH];

    // Entry is ready once both operands hold values
    always_comb
    begin
        for (int i = 0; i < RS_DEPTH; i++)
        begin
            ready[i] = cells[i].busy && !cells[i].qj_pend && !cells[i].qk_pend;
        end
    end

    assign issue_cell = cells[issue_tag];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < RS_DEPTH; i++)
            begin
                cells[i].busy <= 1'b0;
            end
        end
        else
        begin
            // Wakeup on a matching bus tag
            if (cdb_in.valid)
            begin
                for (int i = 0; i < RS_DEPTH; i++)
                begin
                    if (cells[i].busy && cells[i].qj_pend && cells[i].qj == cdb_in.tag)
                    begin
                        cells[i].vj      <= cdb_in.value;
                        cells[i].qj_pend <= 1'b0;
                    end
                    if (cells[i].busy && cells[i].qk_pend && cells[i].qk == cdb_in.tag)
                    begin
                        cells[i].vk      <= cdb_in.value;
                        cells[i].qk_pend <= 1'b0;
                    end
                end
            end

            if (issue_en)
                cells[issue_tag].busy <= 1'b0;

            if (wr_en)
                cells[wr_addr] <= wr_cell;
        end
    end

    // Rename must never hand out a tag whose entry is still occupied
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !cells[wr_addr].busy)
        else $error("dispatch overwrites busy station entry %0d", wr_addr);

endmodule

// File: verilog/issue_ctrl.sv
// Issue and broadcast controller
`timescale 1ns/1ps

module issue_ctrl
#(
    parameter int RS_DEPTH = qu_common_pkg::RS_DEPTH
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [RS_DEPTH-1:0]       ready,
    output logic                      issue_en,
    output qu_common_pkg::rs_tag_t    issue_tag,
    input  qu_uop_pkg::res_st_cell_t  issue_cell,
    output logic                      start,
    output qu_uop_pkg::op_e           op,
    output qu_common_pkg::data_t      a,
    output qu_common_pkg::data_t      b,
    input  logic                      done,
    input  qu_common_pkg::data_t      result,
    output qu_uop_pkg::cdb_t          cdb_out
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_BCAST
    } state_e;

    state_e                    state;
    qu_common_pkg::rs_tag_t    exec_tag;
    qu_common_pkg::reg_addr_t  exec_rd;

    // Lowest ready entry wins
    always_comb
    begin
        issue_tag = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)
        begin
            if (ready[i])
                issue_tag = qu_common_pkg::rs_tag_t'(i);
        end
    end

    assign issue_en = (state == S_IDLE) && (|ready);
    assign start    = issue_en;
    assign op       = issue_cell.op;
    assign a        = issue_cell.vj;
    assign b        = issue_cell.vk;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= S_IDLE;
            cdb_out.valid <= 1'b0;
        end
        else
        begin
            cdb_out.valid <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (issue_en)
                        state <= S_EXEC;
                end
                S_EXEC:
                begin
                    if (done)
                    begin
                        cdb_out.valid <= 1'b1;
                        state         <= S_BCAST;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Tag, rd and result payload
    always_ff @(posedge clk)
    begin
        if (issue_en)
        begin
            exec_tag <= issue_tag;
            exec_rd  <= issue_cell.rd;
        end
        if (state == S_EXEC && done)
        begin
            cdb_out.tag   <= exec_tag;
            cdb_out.rd    <= exec_rd;
            cdb_out.value <= result;
        end
    end

    // Execution unit only reports back while an op is outstanding
    assert property (@(posedge clk) disable iff (rst)
        done |-> state == S_EXEC)
        else $error("execution done raised while no op is executing");

endmodule

// File: verilog/exec_unit.sv
// Shared execution unit
`timescale 1ns/1ps

module exec_unit
#(
    parameter int MUL_LATENCY = 4
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  qu_uop_pkg::op_e       op,
    input  qu_common_pkg::data_t  a,
    input  qu_common_pkg::data_t  b,
    output logic                  done,
    output qu_common_pkg::data_t  result
);

    localparam int CNT_W = $clog2(MUL_LATENCY + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done <= 1'b0;
            cnt  <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                // ALU ops finish next cycle, multiply waits on the counter
                if (op != qu_uop_pkg::OP_MUL || MUL_LATENCY <= 1)
                    done <= 1'b1;
                else
                    cnt <= CNT_W'(MUL_LATENCY - 1);
            end
            else if (cnt != '0)
            begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1))
                    done <= 1'b1;
            end
        end
    end

    // Result is held until the next start
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            case (op)
                qu_uop_pkg::OP_ADD: result <= a + b;
                qu_uop_pkg::OP_SUB: result <= a - b;
                qu_uop_pkg::OP_AND: result <= a & b;
                qu_uop_pkg::OP_XOR: result <= a ^ b;
                default:            result <= a * b;
            endcase
        end
    end

endmodule

// File: verilog/qu_backend.sv
// Out-of-order back end top level
`timescale 1ns/1ps

module qu_backend
#(
    parameter int REG_COUNT   = qu_common_pkg::REG_COUNT,
    parameter int RS_DEPTH    = qu_common_pkg::RS_DEPTH,
    parameter int MUL_LATENCY = 4
)
(
    input  logic               clk,
    input  logic               rst,
    input  qu_uop_pkg::uop_t   uop_in,
    output qu_uop_pkg::cdb_t   cdb_out
);

    // Rename to busy table and register file
    qu_common_pkg::reg_addr_t  bt_rd1_addr;
    qu_common_pkg::reg_addr_t  bt_rd2_addr;
    logic                      bt_rd1_busy;
    logic                      bt_rd2_busy;
    qu_common_pkg::reg_addr_t  rf_rd1_addr;
    qu_common_pkg::reg_addr_t  rf_rd2_addr;
    qu_common_pkg::data_t      rf_rd1_data;
    qu_common_pkg::data_t      rf_rd2_data;
    logic                      busy_set;
    logic                      busy_clr;
    qu_common_pkg::reg_addr_t  busy_set_addr;
    qu_common_pkg::reg_addr_t  busy_clr_addr;

    // Dispatch into the station
    logic                      rs_wr_en;
    qu_common_pkg::rs_tag_t    rs_wr_addr;
    qu_uop_pkg::res_st_cell_t  rs_wr_cell;

    // Issue and execution
    logic [RS_DEPTH-1:0]       ready;
    logic                      issue_en;
    qu_common_pkg::rs_tag_t    issue_tag;
    qu_uop_pkg::res_st_cell_t  issue_cell;
    logic                      ex_start;
    qu_uop_pkg::op_e           ex_op;
    qu_common_pkg::data_t      ex_a;
    qu_common_pkg::data_t      ex_b;
    logic                      ex_done;
    qu_common_pkg::data_t      ex_result;

    rename #(.REG_COUNT(REG_COUNT), .RS_DEPTH(RS_DEPTH)) u_rename (
        .clk(clk), .rst(rst), .uop_in(uop_in),
        .bt_rd1_addr(bt_rd1_addr), .bt_rd2_addr(bt_rd2_addr),
        .bt_rd1_busy(bt_rd1_busy), .bt_rd2_busy(bt_rd2_busy),
        .rf_rd1_addr(rf_rd1_addr), .rf_rd2_addr(rf_rd2_addr),
        .rf_rd1_data(rf_rd1_data), .rf_rd2_data(rf_rd2_data),
        .cdb_in(cdb_out),
        .busy_set(busy_set), .busy_clr(busy_clr),
        .busy_set_addr(busy_set_addr), .busy_clr_addr(busy_clr_addr),
        .rs_wr_en(rs_wr_en), .rs_wr_addr(rs_wr_addr), .rs_wr_cell(rs_wr_cell)
    );

    busy_table #(.REG_COUNT(REG_COUNT)) u_busy_table (
        .clk(clk), .rst(rst),
        .busy_set(busy_set), .busy_set_addr(busy_set_addr),
        .busy_clr(busy_clr), .busy_clr_addr(busy_clr_addr),
        .rd1_addr(bt_rd1_addr), .rd2_addr(bt_rd2_addr),
        .rd1_busy(bt_rd1_busy), .rd2_busy(bt_rd2_busy)
    );

    phy_reg_file #(.REG_COUNT(REG_COUNT)) u_phy_reg_file (
        .clk(clk), .rst(rst),
        .rd1_addr(rf_rd1_addr), .rd2_addr(rf_rd2_addr),
        .rd1_data(rf_rd1_data), .rd2_data(rf_rd2_data),
        .cdb_in(cdb_out)
    );

    res_station #(.RS_DEPTH(RS_DEPTH)) u_res_station (
        .clk(clk), .rst(rst),
        .wr_en(rs_wr_en), .wr_addr(rs_wr_addr), .wr_cell(rs_wr_cell),
        .cdb_in(cdb_out), .ready(ready),
        .issue_en(issue_en), .issue_tag(issue_tag), .issue_cell(issue_cell)
    );

    issue_ctrl #(.RS_DEPTH(RS_DEPTH)) u_issue_ctrl (
        .clk(clk), .rst(rst), .ready(ready),
        .issue_en(issue_en), .issue_tag(issue_tag), .issue_cell(issue_cell),
        .start(ex_start), .op(ex_op), .a(ex_a), .b(ex_b),
        .done(ex_done), .result(ex_result), .cdb_out(cdb_out)
    );

    exec_unit #(.MUL_LATENCY(MUL_LATENCY)) u_exec_unit (
        .clk(clk), .rst(rst),
        .start(ex_start), .op(ex_op), .a(ex_a), .b(ex_b),
        .done(ex_done), .result(ex_result)
    );

endmodule

// File: bench/qu_backend_tb.sv
// Back end testbench
`timescale 1ns/1ps

module qu_backend_tb;

    localparam int REG_COUNT   = qu_common_pkg::REG_COUNT;
    localparam int RS_DEPTH    = qu_common_pkg::RS_DEPTH;
    localparam int MUL_LATENCY = 4;
    localparam int WAIT_LIMIT  = 200;
    localparam int RANDOM_OPS  = 300;

    logic              clk;
    logic              rst;
    qu_uop_pkg::uop_t  uop_in;
    qu_uop_pkg::cdb_t  cdb_out;

    // Reference model, indexed by tag where it tracks ops
    qu_common_pkg::data_t      arch_regs [REG_COUNT];
    qu_common_pkg::data_t      expected [RS_DEPTH];
    qu_common_pkg::reg_addr_t  exp_rd [RS_DEPTH];
    qu_uop_pkg::op_e           exp_op [RS_DEPTH];
    logic [RS_DEPTH-1:0]       in_flight;
    logic [REG_COUNT-1:0]      pend_rd;
    qu_common_pkg::rs_tag_t    next_tag;
    int                        n_in_flight;
    int                        cyc;
    int                        last_bcast;
    logic [15:0]               lfsr;

    qu_backend #(
        .REG_COUNT(REG_COUNT),
        .RS_DEPTH(RS_DEPTH),
        .MUL_LATENCY(MUL_LATENCY)
    ) uut (
        .clk(clk),
        .rst(rst),
        .uop_in(uop_in),
        .cdb_out(cdb_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | 32'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic qu_common_pkg::data_t calc_result(input qu_uop_pkg::op_e op,
                                                         input qu_common_pkg::data_t a,
                                                         input qu_common_pkg::data_t b);
        case (op)
            qu_uop_pkg::OP_ADD: return a + b;
            qu_uop_pkg::OP_SUB: return a - b;
            qu_uop_pkg::OP_AND: return a & b;
            qu_uop_pkg::OP_XOR: return a ^ b;
            qu_uop_pkg::OP_MUL: return a * b;
            default:            return '0;
        endcase
    endfunction

    // Broadcast seen at the edge retires after the checks have sampled it
    task automatic step_cycle();
        qu_uop_pkg::cdb_t seen;
        seen = cdb_out;
        @(posedge clk);
        #1;
        uop_in = '0;
        if (seen.valid)
        begin
            in_flight[seen.tag] = 1'b0;
            pend_rd[exp_rd[seen.tag]] = 1'b0;
            n_in_flight--;
            last_bcast = cyc;
        end
        cyc++;
    endtask

    // Next tag must be free, and rd must have no older writer still pending
    task automatic wait_for_slot(input qu_common_pkg::reg_addr_t rd);
        int waited;
        waited = 0;
        while (in_flight[next_tag] || pend_rd[rd] || n_in_flight >= RS_DEPTH)
        begin
            if (waited >= WAIT_LIMIT)
            begin
                $display("Timeout waiting for station entry %0d and register r%0d",
                         next_tag, rd);
                stop_on_error();
            end
            step_cycle();
            waited++;
        end
    endtask

    task automatic dispatch_op(input qu_uop_pkg::op_e op,
                               input qu_common_pkg::reg_addr_t rs1,
                               input qu_common_pkg::reg_addr_t rs2,
                               input qu_common_pkg::reg_addr_t rd);
        qu_common_pkg::data_t value;
        wait_for_slot(rd);
        // Program order result
        value = calc_result(op, arch_regs[rs1], arch_regs[rs2]);
        arch_regs[rd] = value;
        expected[next_tag] = value;
        exp_rd[next_tag] = rd;
        exp_op[next_tag] = op;
        in_flight[next_tag] = 1'b1;
        pend_rd[rd] = 1'b1;
        n_in_flight++;
        uop_in.valid = 1'b1;
        uop_in.op = op;
        uop_in.rs1 = rs1;
        uop_in.rs2 = rs2;
        uop_in.rd = rd;
        next_tag = qu_common_pkg::rs_tag_t'((int'(next_tag) + 1) % RS_DEPTH);
        step_cycle();
    endtask

    task automatic drain_all();
        int waited;
        waited = 0;
        while (n_in_flight != 0)
        begin
            if (waited >= WAIT_LIMIT * 2)
            begin
                $display("Timeout draining, %0d ops never broadcast", n_in_flight);
                stop_on_error();
            end
            step_cycle();
            waited++;
        end
    endtask

    assert property (@(posedge clk) disable iff (rst)
        cdb_out.valid |-> in_flight[cdb_out.tag])
    else
    begin
        $display("Broadcast of tag %0d while no op with that tag is in flight",
                 $sampled(cdb_out.tag));
        stop_on_error();
    end

    assert property (@(posedge clk) disable iff (rst)
        (cdb_out.valid && in_flight[cdb_out.tag]) |-> cdb_out.rd == exp_rd[cdb_out.tag])
    else
    begin
        $display("ERR cdb_out.rd got %h expected %h",
                 $sampled(cdb_out.rd), exp_rd[$sampled(cdb_out.tag)]);
        stop_on_error();
    end

    assert property (@(posedge clk) disable iff (rst)
        (cdb_out.valid && in_flight[cdb_out.tag]) |-> cdb_out.value == expected[cdb_out.tag])
    else
    begin
        $display("ERR cdb_out.value got %h expected %h",
                 $sampled(cdb_out.value), expected[$sampled(cdb_out.tag)]);
        stop_on_error();
    end

    // Multiply needs its full latency after the bus frees up
    assert property (@(posedge clk) disable iff (rst)
        (cdb_out.valid && exp_op[cdb_out.tag] == qu_uop_pkg::OP_MUL)
            |-> (cyc - last_bcast) >= MUL_LATENCY + 1)
    else
    begin
        $display("Multiply result of tag %0d arrived only %0d cycles after the last broadcast",
                 $sampled(cdb_out.tag), cyc - last_bcast);
        stop_on_error();
    end

    initial
    begin
        qu_uop_pkg::op_e           op;
        qu_common_pkg::reg_addr_t  rs1;
        qu_common_pkg::reg_addr_t  rs2;
        qu_common_pkg::reg_addr_t  rd;
        qu_common_pkg::reg_addr_t  prev_rd;
        int unsigned               pick;

        rst = 1'b1;
        uop_in = '0;
        lfsr = 16'd8;
        for (int r = 0; r < REG_COUNT; r++)
        begin
            arch_regs[r] = qu_common_pkg::data_t'(r);
        end
        in_flight = '0;
        pend_rd = '0;
        next_tag = '0;
        n_in_flight = 0;
        cyc = 0;
        last_bcast = 0;
        prev_rd = '0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Random mix, about half the ops read the previous result
        for (int n = 0; n < RANDOM_OPS; n++)
        begin
            pick = rand_bits(3);
            op = (pick < 5) ? qu_uop_pkg::op_e'(pick[2:0]) : qu_uop_pkg::OP_ADD;
            rs1 = qu_common_pkg::reg_addr_t'(rand_bits(5));
            rs2 = qu_common_pkg::reg_addr_t'(rand_bits(5));
            rd = qu_common_pkg::reg_addr_t'(rand_bits(5));
            if (rand_bits(1) != 0)
                rs1 = prev_rd;
            dispatch_op(op, rs1, rs2, rd);
            prev_rd = rd;
            if (rand_bits(2) == 0)
                step_cycle();
        end
        drain_all();

        // Back to back chain r10 to r17, multiplies in between
        dispatch_op(qu_uop_pkg::OP_ADD, 5'd3, 5'd4, 5'd10);
        for (int i = 0; i < 7; i++)
        begin
            op = (i % 2 == 0) ? qu_uop_pkg::OP_MUL : qu_uop_pkg::OP_SUB;
            dispatch_op(op, qu_common_pkg::reg_addr_t'(10 + i),
                        qu_common_pkg::reg_addr_t'(i),
                        qu_common_pkg::reg_addr_t'(11 + i));
        end
        drain_all();

        // Every register read back from the settled register file
        for (int r = 0; r < REG_COUNT; r++)
        begin
            rd = qu_common_pkg::reg_addr_t'(r);
            dispatch_op(qu_uop_pkg::OP_AND, rd, rd, rd);
        end
        drain_all();

        $display("Test OK");
        $finish;
    end

endmodule

// File: qu_backend.f
verilog/qu_common_pkg.sv
verilog/qu_uop_pkg.sv
verilog/busy_table.sv
verilog/phy_reg_file.sv
verilog/rename.sv
verilog/res_station.sv
verilog/issue_ctrl.sv
verilog/exec_unit.sv
verilog/qu_backend.sv
bench/qu_backend_tb.sv

// File: Makefile
# Verilator build and run for the qu_backend testbench

VERILATOR ?= verilator
FILELIST  ?= qu_backend.f
TB_TOP    ?= qu_backend_tb
DUT_TOP   ?= qu_backend
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out=$$($(BUILD_DIR)/V$(TB_TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
